// ==== async_fifo/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo (
  input  logic                 wr_clk,
  input  logic                 rd_clk,
  input  logic                 wr_rst_n,
  input  logic                 rd_rst_n,
  input  logic                 wr_en,
  input  cdc_pkg::fifo_word_t  wr_data,
  output logic                 wr_full,
  input  logic                 rd_en,
  output cdc_pkg::fifo_word_t  rd_data,
  output logic                 rd_empty,
  output cdc_pkg::fifo_level_t rd_level
);

  logic               wr_vld;
  logic               rd_vld;
  logic               full_comb;
  logic               empty_comb;
  cdc_pkg::fifo_ptr_t wr_ptr;
  cdc_pkg::fifo_ptr_t wr_ptr_nxt;
  cdc_pkg::fifo_ptr_t wr_gray_nxt;
  cdc_pkg::fifo_ptr_t rd_ptr;
  cdc_pkg::fifo_ptr_t rd_ptr_nxt;
  cdc_pkg::fifo_ptr_t rd_gray_nxt;
  cdc_pkg::fifo_ptr_t rd_gray_wsync;
  cdc_pkg::fifo_ptr_t wr_gray_rsync;
  cdc_pkg::fifo_ptr_t wr_bin_rsync;

  assign wr_vld = wr_en && !wr_full;
  assign rd_vld = rd_en && !rd_empty;

  fifo_mem fifo_mem_inst (
    .wr_clk  (wr_clk),
    .wr_en   (wr_vld),
    .wr_addr (wr_ptr[cdc_pkg::ADDR_WIDTH-1:0]),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rd_en   (rd_vld),
    .rd_addr (rd_ptr[cdc_pkg::ADDR_WIDTH-1:0]),
    .rd_data (rd_data)
  );

  // ********************************************************************
  // write domain
  // ********************************************************************
  assign wr_ptr_nxt  = wr_vld ? wr_ptr + 1'b1 : wr_ptr;
  assign wr_gray_nxt = wr_ptr_nxt ^ (wr_ptr_nxt >> 1);

  // full when the write pointer is one lap ahead of the read pointer
  assign full_comb = wr_gray_nxt == {
    ~rd_gray_wsync[cdc_pkg::PTR_WIDTH-1:cdc_pkg::PTR_WIDTH-2],
    rd_gray_wsync[cdc_pkg::PTR_WIDTH-3:0]
  };

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr  <= '0;
      wr_full <= 1'b0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_full <= full_comb;
    end
  end

  // ********************************************************************
  // read domain
  // ********************************************************************
  assign rd_ptr_nxt  = rd_vld ? rd_ptr + 1'b1 : rd_ptr;
  assign rd_gray_nxt = rd_ptr_nxt ^ (rd_ptr_nxt >> 1);
  assign empty_comb  = rd_gray_nxt == wr_gray_rsync;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr   <= '0;
      rd_empty <= 1'b1;
    end else begin
      rd_ptr   <= rd_ptr_nxt;
      rd_empty <= empty_comb;
    end
  end

  assign rd_level = wr_bin_rsync - rd_ptr;

  // write pointer into the read domain
  gray_sync wr2rd_sync_inst (
    .src_clk   (wr_clk),
    .src_rst_n (wr_rst_n),
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .src_ptr   (wr_ptr_nxt),
    .dst_gray  (wr_gray_rsync),
    .dst_bin   (wr_bin_rsync)
  );

  // read pointer into the write domain where only the gray value is needed
  gray_sync rd2wr_sync_inst (
    .src_clk   (rd_clk),
    .src_rst_n (rd_rst_n),
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .src_ptr   (rd_ptr_nxt),
    .dst_gray  (rd_gray_wsync),
    .dst_bin   ()
  );

endmodule

// ==== async_fifo/fifo_mem.sv ====
`timescale 1ns/1ps

module fifo_mem (
  input  logic                           wr_clk,
  input  logic                           wr_en,
  input  logic [cdc_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  cdc_pkg::fifo_word_t            wr_data,
  input  logic                           rd_clk,
  input  logic                           rd_en,
  input  logic [cdc_pkg::ADDR_WIDTH-1:0] rd_addr,
  output cdc_pkg::fifo_word_t            rd_data
);

  cdc_pkg::fifo_word_t mem [cdc_pkg::FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read data holds until the next accepted read
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== async_fifo/gray_sync.sv ====
`timescale 1ns/1ps

module gray_sync (
  input  logic               src_clk,
  input  logic               src_rst_n,
  input  logic               dst_clk,
  input  logic               dst_rst_n,
  input  cdc_pkg::fifo_ptr_t src_ptr,
  output cdc_pkg::fifo_ptr_t dst_gray,
  output cdc_pkg::fifo_ptr_t dst_bin
);

  cdc_pkg::fifo_ptr_t src_gray;
  cdc_pkg::fifo_ptr_t sync_q1;
  cdc_pkg::fifo_ptr_t sync_q2;

  // only one bit changes per step, so the crossing is safe
  always_ff @(posedge src_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      src_gray <= '0;
    end else begin
      src_gray <= src_ptr ^ (src_ptr >> 1);
    end
  end

  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= src_gray;
      sync_q2 <= sync_q1;
    end
  end

  assign dst_gray = sync_q2;

  // each binary bit is the xor of all gray bits at and above it
  always_comb begin
    for (int i = 0; i < cdc_pkg::PTR_WIDTH; i++) begin
      dst_bin[i] = ^(sync_q2 >> i);
    end
  end

endmodule

// ==== common/cdc_pkg.sv ====
package cdc_pkg;

  // ********************************************************************
  // sizes
  // ********************************************************************
  localparam int DATA_WIDTH     = 16;
  localparam int FIFO_DEPTH     = 16;
  localparam int ADDR_WIDTH     = 4;
  localparam int PTR_WIDTH      = ADDR_WIDTH + 1;
  localparam int LEVEL_WIDTH    = 5;
  localparam int TIMER_WIDTH    = 8;
  localparam int APB_ADDR_WIDTH = 4;
  localparam int APB_DATA_WIDTH = 32;

  // burst_len field position inside REG_CTRL
  localparam int CTRL_LEN_LSB   = 8;

  typedef logic [DATA_WIDTH-1:0]  fifo_word_t;
  typedef logic [PTR_WIDTH-1:0]   fifo_ptr_t;
  typedef logic [LEVEL_WIDTH-1:0] fifo_level_t;

  typedef struct packed {
    fifo_word_t data;
    logic       last;
  } out_beat_t;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    SEND
  } drain_state_e;

  typedef enum logic [APB_ADDR_WIDTH-1:0] {
    REG_CTRL    = 4'h0,
    REG_TIMEOUT = 4'h4,
    REG_STATUS  = 4'h8
  } reg_addr_e;

  // ********************************************************************
  // APB and configuration bundles
  // ********************************************************************
  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic                   enable;
    fifo_level_t            burst_len;
    logic [TIMER_WIDTH-1:0] flush_timeout;
  } drain_cfg_t;

endpackage

// ==== project.f ====
+incdir+test
common/cdc_pkg.sv
async_fifo/fifo_mem.sv
async_fifo/gray_sync.sv
async_fifo/async_fifo.sv
rtl/drain_ctrl.sv
rtl/flush_timer.sv
rtl/apb_regs.sv
rtl/cdc_bridge_top.sv
test/tb_cdc_bridge.sv

// ==== rtl/apb_regs.sv ====
`timescale 1ns/1ps

module apb_regs (
  input  logic                 rd_clk,
  input  logic                 rd_rst_n,
  input  cdc_pkg::apb_req_t    apb_req,
  input  cdc_pkg::fifo_level_t rd_level,
  output cdc_pkg::apb_rsp_t    apb_rsp,
  output cdc_pkg::drain_cfg_t  cfg
);

  logic                               access;
  logic                               addr_ok;
  logic [cdc_pkg::APB_DATA_WIDTH-1:0] rdata;
  cdc_pkg::fifo_level_t               wr_len;

  assign access = apb_req.psel && apb_req.penable;
  assign wr_len = apb_req.pwdata[cdc_pkg::CTRL_LEN_LSB +: cdc_pkg::LEVEL_WIDTH];

  // ********************************************************************
  // read decode
  // ********************************************************************
  always_comb begin
    addr_ok = 1'b1;
    rdata   = '0;
    case (apb_req.paddr)
      cdc_pkg::REG_CTRL: begin
        rdata[0] = cfg.enable;
        rdata[cdc_pkg::CTRL_LEN_LSB +: cdc_pkg::LEVEL_WIDTH] = cfg.burst_len;
      end
      cdc_pkg::REG_TIMEOUT: begin
        rdata[cdc_pkg::TIMER_WIDTH-1:0] = cfg.flush_timeout;
      end
      cdc_pkg::REG_STATUS: begin
        rdata[cdc_pkg::LEVEL_WIDTH-1:0] = rd_level;
      end
      default: begin
        addr_ok = 1'b0;
      end
    endcase
  end

  // no wait states
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.prdata  = access ? rdata : '0;
  assign apb_rsp.pslverr = access && !addr_ok;

  // ********************************************************************
  // writes land at the end of the access phase
  // ********************************************************************
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      cfg.enable        <= 1'b1;
      cfg.burst_len     <= cdc_pkg::fifo_level_t'(4);
      cfg.flush_timeout <= '0;
    end else if (access && apb_req.pwrite) begin
      if (apb_req.paddr == cdc_pkg::REG_CTRL) begin
        cfg.enable    <= apb_req.pwdata[0];
        // a zero length would never finish a burst
        cfg.burst_len <= (wr_len == '0) ? cdc_pkg::fifo_level_t'(1) : wr_len;
      end else if (apb_req.paddr == cdc_pkg::REG_TIMEOUT) begin
        cfg.flush_timeout <= apb_req.pwdata[cdc_pkg::TIMER_WIDTH-1:0];
      end
    end
  end

endmodule

// ==== rtl/cdc_bridge_top.sv ====
`timescale 1ns/1ps

module cdc_bridge_top (
  input  logic                wr_clk,
  input  logic                rd_clk,
  input  logic                wr_rst_n,
  input  logic                wr_en,
  input  cdc_pkg::fifo_word_t wr_data,
  input  logic                out_ready,
  input  cdc_pkg::apb_req_t   apb_req,
  output logic                wr_full,
  output logic                out_valid,
  output cdc_pkg::out_beat_t  out_beat,
  output cdc_pkg::apb_rsp_t   apb_rsp
);

  logic [1:0]           rst_sync_q;
  logic                 rd_rst_n;
  logic                 rd_en;
  logic                 rd_empty;
  cdc_pkg::fifo_level_t rd_level;
  cdc_pkg::fifo_word_t  rd_data;
  cdc_pkg::drain_cfg_t  cfg;
  logic                 flush_req;
  logic                 burst_start;
  logic                 pending;

  // assert at once, release two rd_clk edges later
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rd_rst_n = rst_sync_q[1];

  // words waiting while no burst is running
  assign pending = !rd_empty && !rd_en && !out_valid;

  async_fifo async_fifo_inst (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_rst_n (rd_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .wr_full  (wr_full),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_empty (rd_empty),
    .rd_level (rd_level)
  );

  drain_ctrl drain_ctrl_inst (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .cfg         (cfg),
    .rd_empty    (rd_empty),
    .rd_level    (rd_level),
    .rd_data     (rd_data),
    .flush_req   (flush_req),
    .out_ready   (out_ready),
    .rd_en       (rd_en),
    .burst_start (burst_start),
    .out_valid   (out_valid),
    .out_beat    (out_beat)
  );

  flush_timer flush_timer_inst (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .timeout   (cfg.flush_timeout),
    .pending   (pending),
    .restart   (burst_start),
    .flush_req (flush_req)
  );

  apb_regs apb_regs_inst (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .apb_req  (apb_req),
    .rd_level (rd_level),
    .apb_rsp  (apb_rsp),
    .cfg      (cfg)
  );

endmodule

// ==== rtl/drain_ctrl.sv ====
`timescale 1ns/1ps

module drain_ctrl (
  input  logic                 rd_clk,
  input  logic                 rd_rst_n,
  input  cdc_pkg::drain_cfg_t  cfg,
  input  logic                 rd_empty,
  input  cdc_pkg::fifo_level_t rd_level,
  input  cdc_pkg::fifo_word_t  rd_data,
  input  logic                 flush_req,
  input  logic                 out_ready,
  output logic                 rd_en,
  output logic                 burst_start,
  output logic                 out_valid,
  output cdc_pkg::out_beat_t   out_beat
);

  cdc_pkg::drain_state_e state_q;
  cdc_pkg::drain_state_e state_d;
  cdc_pkg::fifo_level_t  remain_q;
  cdc_pkg::fifo_level_t  remain_d;
  logic                  full_ready;
  logic                  flush_ready;
  logic                  xfer;

  assign full_ready  = rd_level >= cfg.burst_len;
  assign flush_ready = flush_req && (rd_level != '0);
  assign burst_start = (state_q == cdc_pkg::IDLE) && cfg.enable && (full_ready || flush_ready);

  // one word outside the FIFO at a time
  assign rd_en     = (state_q == cdc_pkg::FETCH) && !rd_empty;
  assign out_valid = state_q == cdc_pkg::SEND;
  assign xfer      = out_valid && out_ready;

  // memory read port holds its data while in SEND
  assign out_beat.data = rd_data;
  assign out_beat.last = remain_q == cdc_pkg::fifo_level_t'(1);

  always_comb begin
    state_d  = state_q;
    remain_d = remain_q;
    case (state_q)
      cdc_pkg::IDLE: begin
        if (burst_start) begin
          state_d  = cdc_pkg::FETCH;
          // a flush takes whatever is there
          remain_d = full_ready ? cfg.burst_len : rd_level;
        end
      end
      cdc_pkg::FETCH: begin
        if (rd_en) begin
          state_d = cdc_pkg::SEND;
        end
      end
      cdc_pkg::SEND: begin
        if (xfer) begin
          remain_d = remain_q - 1'b1;
          state_d  = out_beat.last ? cdc_pkg::IDLE : cdc_pkg::FETCH;
        end
      end
      default: begin
        state_d = cdc_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state_q  <= cdc_pkg::IDLE;
      remain_q <= '0;
    end else begin
      state_q  <= state_d;
      remain_q <= remain_d;
    end
  end

endmodule

// ==== rtl/flush_timer.sv ====
`timescale 1ns/1ps

module flush_timer (
  input  logic                            rd_clk,
  input  logic                            rd_rst_n,
  input  logic [cdc_pkg::TIMER_WIDTH-1:0] timeout,
  input  logic                            pending,
  input  logic                            restart,
  output logic                            flush_req
);

  logic [cdc_pkg::TIMER_WIDTH-1:0] count_q;

  // counts waiting cycles and saturates at the timeout
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      count_q <= '0;
    end else if (restart || !pending) begin
      count_q <= '0;
    end else if (count_q != timeout) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Zero timeout never fires
  assign flush_req = pending && (timeout != '0) && (count_q == timeout);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cdc_bridge -f project.f

sim_out=$(./obj_dir/Vtb_cdc_bridge)
echo "$sim_out"
echo "$sim_out" | grep -qx "TB PASSED"

// ==== test/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// **********************************************************************
// compare checks
// **********************************************************************
task automatic check_word(input cdc_pkg::fifo_word_t got, input cdc_pkg::fifo_word_t exp,
                          input string what);
  if (got !== exp) begin
    $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    mismatch_count++;
  end
endtask

task automatic check_beat(input cdc_pkg::out_beat_t got, input cdc_pkg::out_beat_t exp,
                          input string what);
  if (got !== exp) begin
    $display("Mismatch at %0t: %s got data %h last %b expected data %h last %b",
             $time, what, got.data, got.last, exp.data, exp.last);
    mismatch_count++;
  end
endtask

task automatic check_rsp(input cdc_pkg::apb_rsp_t got, input cdc_pkg::apb_rsp_t exp,
                         input logic check_data, input string what);
  if (got.pready !== exp.pready || got.pslverr !== exp.pslverr ||
      (check_data && got.prdata !== exp.prdata)) begin
    $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    mismatch_count++;
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    mismatch_count++;
  end
endtask

// REG_CTRL holds enable in bit 0 and the burst length in bits 12:8
function automatic logic [31:0] ctrl_value(input logic enable, input logic [4:0] len);
  return {19'd0, len, 7'd0, enable};
endfunction

function automatic cdc_pkg::apb_rsp_t make_rsp(input logic [31:0] prdata, input logic pslverr);
  cdc_pkg::apb_rsp_t rsp;
  rsp.prdata  = prdata;
  rsp.pready  = 1'b1;
  rsp.pslverr = pslverr;
  return rsp;
endfunction

// **********************************************************************
// drivers
// **********************************************************************
task automatic wait_rd_cycles(input int n);
  repeat (n) @(posedge rd_clk);
endtask

task automatic write_word(input cdc_pkg::fifo_word_t data, input logic wait_room,
                          output logic accepted);
  @(posedge wr_clk);
  wr_en   <= 1'b1;
  wr_data <= data;
  // the next edge takes the word unless wr_full is up
  @(negedge wr_clk);
  while (wait_room && wr_full) @(negedge wr_clk);
  accepted = !wr_full;
  @(posedge wr_clk);
  wr_en <= 1'b0;
endtask

task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                          output cdc_pkg::apb_rsp_t rsp);
  @(posedge rd_clk);
  apb_req.psel    <= 1'b1;
  apb_req.penable <= 1'b0;
  apb_req.pwrite  <= write;
  apb_req.paddr   <= addr;
  apb_req.pwdata  <= wdata;
  @(posedge rd_clk);
  apb_req.penable <= 1'b1;
  // access phase ends on the first edge with pready high
  @(negedge rd_clk);
  while (!apb_rsp.pready) @(negedge rd_clk);
  rsp = apb_rsp;
  @(posedge rd_clk);
  apb_req <= '0;
endtask

task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
  cdc_pkg::apb_rsp_t rsp;
  apb_access(1'b1, addr, wdata, rsp);
  check_rsp(rsp, make_rsp(32'd0, 1'b0), 1'b0, "apb write response");
endtask

task automatic apb_read_check(input logic [3:0] addr, input logic [31:0] exp, input string what);
  cdc_pkg::apb_rsp_t rsp;
  apb_access(1'b0, addr, 32'd0, rsp);
  check_rsp(rsp, make_rsp(exp, 1'b0), 1'b1, what);
endtask

// **********************************************************************
// reference queue
// **********************************************************************
task automatic expect_word(input cdc_pkg::fifo_word_t data, input logic last);
  cdc_pkg::out_beat_t beat;
  beat.data = data;
  beat.last = last;
  exp_q.push_back(beat);
endtask

task automatic wait_drain();
  while (exp_q.size() != 0) @(negedge rd_clk);
  // any extra beat would show up in this window
  wait_rd_cycles(20);
endtask

`endif

// ==== test/tb_cdc_bridge.sv ====
`timescale 1ns/1ps

module tb_cdc_bridge;

  // the tests need roughly 1000 rd_clk cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic                rd_clk;
  logic                wr_clk;
  logic                wr_rst_n;
  logic                wr_en;
  cdc_pkg::fifo_word_t wr_data;
  logic                out_ready;
  cdc_pkg::apb_req_t   apb_req;
  logic                wr_full;
  logic                out_valid;
  cdc_pkg::out_beat_t  out_beat;
  cdc_pkg::apb_rsp_t   apb_rsp;

  int                  mismatch_count;
  int                  fail_count;
  int                  rx_count;
  int                  cycle_count;
  int                  seed;
  logic                random_ready;
  logic [31:0]         ready_rnd;
  logic                stall_seen;
  cdc_pkg::out_beat_t  stall_beat;
  cdc_pkg::fifo_word_t last_rx_data;
  cdc_pkg::out_beat_t  exp_q[$];

  `include "tb_tasks.svh"

  cdc_bridge_top cdc_bridge_top_inst (
    .wr_clk    (wr_clk),
    .rd_clk    (rd_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .out_ready (out_ready),
    .apb_req   (apb_req),
    .wr_full   (wr_full),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .apb_rsp   (apb_rsp)
  );

  initial begin
    rd_clk = 1'b0;
    forever #2 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #3 wr_clk = ~wr_clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge rd_clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d rd_clk cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  // random back-pressure on the output stream
  always @(posedge rd_clk) begin
    if (random_ready) begin
      ready_rnd = $random(seed);
      out_ready <= ready_rnd[0];
    end
  end

  // **********************************************************************
  // output monitor
  // **********************************************************************
  always @(negedge rd_clk) begin
    if (stall_seen) begin
      check_flag(out_valid, 1'b1, "out_valid held under back-pressure");
      check_beat(out_beat, stall_beat, "beat held under back-pressure");
    end
    stall_seen = out_valid && !out_ready;
    stall_beat = out_beat;
    if (out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0t: beat with data %h came out while no word was expected",
                 $time, out_beat.data);
        fail_count++;
      end else begin
        check_beat(out_beat, exp_q.pop_front(), "output beat");
      end
      last_rx_data = out_beat.data;
      rx_count++;
    end
  end

  // **********************************************************************
  // tests
  // **********************************************************************
  task automatic test_reset_values();
    @(negedge rd_clk);
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(wr_full, 1'b0, "wr_full after reset");
    apb_read_check(cdc_pkg::REG_CTRL, ctrl_value(1'b1, 5'd4), "REG_CTRL reset value");
    apb_read_check(cdc_pkg::REG_STATUS, 32'd0, "REG_STATUS reset value");
  endtask

  task automatic test_apb_access();
    cdc_pkg::apb_rsp_t rsp;
    apb_write(cdc_pkg::REG_TIMEOUT, 32'h0000_005a);
    apb_read_check(cdc_pkg::REG_TIMEOUT, 32'h0000_005a, "REG_TIMEOUT readback");
    apb_write(cdc_pkg::REG_CTRL, ctrl_value(1'b0, 5'd7));
    apb_read_check(cdc_pkg::REG_CTRL, ctrl_value(1'b0, 5'd7), "REG_CTRL readback");
    // zero length is kept as one
    apb_write(cdc_pkg::REG_CTRL, ctrl_value(1'b1, 5'd0));
    apb_read_check(cdc_pkg::REG_CTRL, ctrl_value(1'b1, 5'd1), "REG_CTRL zero length");
    apb_access(1'b0, 4'hc, 32'd0, rsp);
    check_rsp(rsp, make_rsp(32'd0, 1'b1), 1'b0, "read of unmapped offset");
    apb_access(1'b1, 4'hc, 32'hffff_ffff, rsp);
    check_rsp(rsp, make_rsp(32'd0, 1'b1), 1'b0, "write of unmapped offset");
  endtask

  task automatic test_full_bursts();
    logic                accepted;
    cdc_pkg::fifo_word_t data;
    apb_write(cdc_pkg::REG_TIMEOUT, 32'd0);
    apb_write(cdc_pkg::REG_CTRL, ctrl_value(1'b1, 5'd4));
    for (int i = 0; i < 8; i++) begin
      data = 16'h3000 + 16'(i);
      expect_word(data, (i % 4) == 3);
      write_word(data, 1'b0, accepted);
      check_flag(accepted, 1'b1, "write in full burst test");
    end
    wait_drain();
  endtask

  task automatic test_flush();
    logic                accepted;
    cdc_pkg::fifo_word_t data;
    apb_write(cdc_pkg::REG_CTRL, ctrl_value(1'b1, 5'd8));
    apb_write(cdc_pkg::REG_TIMEOUT, 32'd20);
    for (int i = 0; i < 3; i++) begin
      data = 16'h4000 + 16'(i);
      expect_word(data, i == 2);
      write_word(data, 1'b0, accepted);
      check_flag(accepted, 1'b1, "write in flush test");
    end
    wait_drain();
  endtask

  task automatic test_back_pressure();
    logic                accepted;
    cdc_pkg::fifo_word_t words [40];
    apb_write(cdc_pkg::REG_TIMEOUT, 32'd0);
    apb_write(cdc_pkg::REG_CTRL, ctrl_value(1'b1, 5'd5));
    for (int i = 0; i < 40; i++) begin
      words[i] = cdc_pkg::fifo_word_t'($random(seed));
    end
    @(posedge rd_clk);
    random_ready <= 1'b1;
    for (int i = 0; i < 40; i++) begin
      expect_word(words[i], (i % 5) == 4);
      write_word(words[i], 1'b1, accepted);
    end
    while (exp_q.size() != 0) @(negedge rd_clk);
    @(posedge rd_clk);
    random_ready <= 1'b0;
    @(posedge rd_clk);
    out_ready <= 1'b1;
    wait_drain();
  endtask

  task automatic test_full_fifo();
    logic accepted;
    apb_write(cdc_pkg::REG_TIMEOUT, 32'd0);
    apb_write(cdc_pkg::REG_CTRL, ctrl_value(1'b0, 5'd4));
    for (int i = 0; i < 16; i++) begin
      write_word(16'h6000 + 16'(i), 1'b0, accepted);
      check_flag(accepted, 1'b1, "write into non-full FIFO");
    end
    @(negedge wr_clk);
    check_flag(wr_full, 1'b1, "wr_full after 16 writes");
    write_word(16'hdead, 1'b0, accepted);
    check_flag(accepted, 1'b0, "write into full FIFO");
    // level reaches rd_clk within three cycles
    wait_rd_cycles(4);
    apb_read_check(cdc_pkg::REG_STATUS, 32'd16, "REG_STATUS with full FIFO");
    for (int i = 0; i < 16; i++) begin
      expect_word(16'h6000 + 16'(i), (i % 4) == 3);
    end
    apb_write(cdc_pkg::REG_CTRL, ctrl_value(1'b1, 5'd4));
    wait_drain();
    check_word(last_rx_data, 16'h600f, "last drained word");
    apb_read_check(cdc_pkg::REG_STATUS, 32'd0, "REG_STATUS after drain");
    @(negedge wr_clk);
    check_flag(wr_full, 1'b0, "wr_full after drain");
  endtask

  initial begin
    wr_rst_n       = 1'b0;
    wr_en          = 1'b0;
    wr_data        = '0;
    out_ready      = 1'b0;
    apb_req        = '0;
    mismatch_count = 0;
    fail_count     = 0;
    rx_count       = 0;
    seed           = 32'h79dd3123;
    random_ready   = 1'b0;
    stall_seen     = 1'b0;
    stall_beat     = '0;
    last_rx_data   = '0;
    repeat (8) @(posedge rd_clk);
    wr_rst_n  <= 1'b1;
    out_ready <= 1'b1;
    wait_rd_cycles(4);

    test_reset_values();
    test_apb_access();
    test_full_bursts();
    test_flush();
    test_back_pressure();
    test_full_fifo();

    $display("summary: %0d mismatches, %0d other errors, %0d beats received",
             mismatch_count, fail_count, rx_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
